// ==== include/board_cfg.svh ====
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Board oscillator
`define BOARD_CLK_MHZ 27

// LCD blanking, in pixel cycles and lines
`define LCD_H_BLANK   24
`define LCD_V_BLANK   6

// Sync widths, must stay below the blanking
`define LCD_HS_LEN    6
`define LCD_VS_LEN    2

// Heartbeat period in clock cycles, keep above 40 * TM_HALF
`define TICK_DIV      400

// Half of one serial clock period, at least 2
`define TM_HALF       4

`endif

// ==== hw/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Test image selection, key bits 2:1
    typedef enum logic [1:0]
    {
        MODE_PLAIN   = 2'd0,
        MODE_STRIPES = 2'd1,
        MODE_CHECKER = 2'd2,
        MODE_COUNT   = 2'd3
    } disp_mode_t;

    // Lab side of the display handshake
    typedef enum logic [1:0]
    {
        LAB_IDLE,
        LAB_REQ,
        LAB_WAIT_RELEASE
    } lab_state_t;

    // Serial controller
    typedef enum logic [1:0]
    {
        TM_IDLE,
        TM_SHIFT_LOW,
        TM_SHIFT_HIGH,
        TM_DONE
    } tm_state_t;

endpackage

`default_nettype wire

// ==== hw/display_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One display update, four-phase req/ack
interface display_if;

    logic       req;
    logic       ack;
    logic [7:0] segments;  // hgfedcba
    logic [7:0] leds;
    logic [7:0] digit;     // One-hot

    modport lab
    (
        output req, segments, leds, digit,
        input  ack
    );

    modport ctrl
    (
        input  req, segments, leds, digit,
        output ack
    );

endinterface

`default_nettype wire

// ==== hw/tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module tick_gen
#(
    parameter int tick_div = `TICK_DIV
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int w_cnt = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt  <= w_cnt'(tick_div - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= w_cnt'(tick_div - 1);  // Reload
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lcd_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module lcd_timing
#(
    parameter int screen_width  = 800,
    parameter int screen_height = 480,
    parameter int w_x           = $clog2(screen_width  + `LCD_H_BLANK),
    parameter int w_y           = $clog2(screen_height + `LCD_V_BLANK)
)
(
    input  logic             clk,
    input  logic             rst,
    output logic             de,
    output logic             hs,
    output logic             vs,
    output logic [w_x - 1:0] x,
    output logic [w_y - 1:0] y
);

    localparam int h_total = screen_width  + `LCD_H_BLANK;
    localparam int v_total = screen_height + `LCD_V_BLANK;

    // ----------------------------------------
    // Pixel and line counters

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Park on the last blank pixel so the first frame is whole
            x <= w_x'(h_total - 1);
            y <= w_y'(v_total - 1);
        end
        else if (x == w_x'(h_total - 1))
        begin
            x <= '0;
            if (y == w_y'(v_total - 1))
                y <= '0;
            else
                y <= y + 1'b1;
        end
        else
        begin
            x <= x + 1'b1;
        end
    end

    // ----------------------------------------
    // Enable and sync decode

    always_comb
    begin
        de = (x < w_x'(screen_width)) && (y < w_y'(screen_height));
        hs = !((x >= w_x'(screen_width))
            && (x <  w_x'(screen_width + `LCD_HS_LEN)));
        vs = !((y >= w_y'(screen_height))
            && (y <  w_y'(screen_height + `LCD_VS_LEN)));
    end

    // Enable ends after the last visible pixel
    a_de_in_width: assert property (@(posedge clk) disable iff (rst)
        (de && (x == w_x'(screen_width - 1))) |=> !de);

endmodule

`default_nettype wire

// ==== hw/lab_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module lab_core
    import board_pkg::*;
#(
    parameter int screen_width  = 800,
    parameter int screen_height = 480,
    parameter int w_x           = $clog2(screen_width  + `LCD_H_BLANK),
    parameter int w_y           = $clog2(screen_height + `LCD_V_BLANK)
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,
    input  logic [2:0]       key,
    input  logic [4:0]       sw,
    input  logic             de,
    input  logic [w_x - 1:0] x,
    input  logic [w_y - 1:0] y,
    output logic [4:0]       red,
    output logic [5:0]       green,
    output logic [4:0]       blue,
    display_if.lab           disp
);

    disp_mode_t mode;
    lab_state_t state;
    logic [7:0] count;
    logic [7:0] last_sent;
    logic       send;

    // Seven-segment pattern, bit 0 is segment a
    function automatic logic [7:0] seg7(input logic [3:0] val);
        case (val)
            4'h0: seg7 = 8'h3f;
            4'h1: seg7 = 8'h06;
            4'h2: seg7 = 8'h5b;
            4'h3: seg7 = 8'h4f;
            4'h4: seg7 = 8'h66;
            4'h5: seg7 = 8'h6d;
            4'h6: seg7 = 8'h7d;
            4'h7: seg7 = 8'h07;
            4'h8: seg7 = 8'h7f;
            4'h9: seg7 = 8'h6f;
            4'ha: seg7 = 8'h77;
            4'hb: seg7 = 8'h7c;
            4'hc: seg7 = 8'h39;
            4'hd: seg7 = 8'h5e;
            4'he: seg7 = 8'h79;
            default: seg7 = 8'h71;
        endcase
    endfunction

    // ----------------------------------------
    // Mode and counter

    always_ff @(posedge clk)
    begin
        if (rst)
            mode <= MODE_PLAIN;
        else if (key[1] || key[2])
            mode <= disp_mode_t'(key[2:1]);
    end

    always_ff @(posedge clk)
    begin
        if (rst || key[0])
            count <= '0;
        else if (tick && sw[0])
            count <= count + 1'b1;
    end

    // ----------------------------------------
    // Test image

    always_comb
    begin
        red   = '0;
        green = '0;
        blue  = '0;
        if (de)
        begin
            case (mode)
                MODE_PLAIN:
                begin
                    red   = sw;
                    green = {sw, sw[4]};
                    blue  = sw;
                end
                MODE_STRIPES: red = {5{x[2]}};
                MODE_CHECKER:
                begin
                    red   = {5{x[2] ^ y[2]}};
                    green = {6{x[2] ^ y[2]}};
                    blue  = {5{x[2] ^ y[2]}};
                end
                default: green = count[7:2];  // MODE_COUNT
            endcase
        end
    end

    // ----------------------------------------
    // Display request sequencer

    assign send       = (state == LAB_IDLE) && (count != last_sent);
    assign disp.digit = 8'b0000_0001;  // Single digit in use

    always_ff @(posedge clk)
    begin
        if (send)
        begin
            disp.segments <= seg7(count[3:0]);
            disp.leds     <= count;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= LAB_IDLE;
            disp.req  <= 1'b0;
            last_sent <= '0;
        end
        else
        begin
            case (state)
                LAB_IDLE:
                    if (send)
                    begin
                        last_sent <= count;  // Newest value only
                        disp.req  <= 1'b1;
                        state     <= LAB_REQ;
                    end
                LAB_REQ:
                    if (disp.ack)
                    begin
                        disp.req <= 1'b0;
                        state    <= LAB_WAIT_RELEASE;
                    end
                default:
                    if (!disp.ack)
                        state <= LAB_IDLE;
            endcase
        end
    end

    a_req_after_release: assert property (@(posedge clk) disable iff (rst)
        $rose(disp.req) |-> !disp.ack);

endmodule

`default_nettype wire

// ==== hw/tm1638_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module tm1638_ctrl
    import board_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    display_if.ctrl disp,
    output logic    sio_clk,
    output logic    sio_stb,
    output logic    sio_data
);

    localparam int w_half = (`TM_HALF > 1) ? $clog2(`TM_HALF) : 1;

    tm_state_t           state;
    logic [15:0]         shreg;
    logic [3:0]          bit_cnt;
    logic [w_half - 1:0] half_cnt;
    logic                half_last;
    logic                start;

    assign half_last = (half_cnt == w_half'(`TM_HALF - 1));
    assign start     = (state == TM_IDLE) && disp.req && !disp.ack;

    // Segments go out first, LSB first
    always_ff @(posedge clk)
    begin
        if (start)
            shreg <= {disp.leds, disp.segments};
        else if (state == TM_SHIFT_HIGH && half_last)
            shreg <= shreg >> 1;
    end

    // ----------------------------------------
    // Serial FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= TM_IDLE;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_data <= 1'b0;
            disp.ack <= 1'b0;
            bit_cnt  <= '0;
            half_cnt <= '0;
        end
        else
        begin
            case (state)
                TM_IDLE:
                    if (start)
                    begin
                        sio_stb  <= 1'b0;
                        sio_clk  <= 1'b0;
                        bit_cnt  <= '0;
                        half_cnt <= '0;
                        state    <= TM_SHIFT_LOW;
                    end
                TM_SHIFT_LOW:
                begin
                    if (half_cnt == '0)
                        sio_data <= shreg[0];  // Clock already low here
                    if (half_last)
                    begin
                        half_cnt <= '0;
                        sio_clk  <= 1'b1;
                        state    <= TM_SHIFT_HIGH;
                    end
                    else
                        half_cnt <= half_cnt + 1'b1;
                end
                TM_SHIFT_HIGH:
                    if (half_last)
                    begin
                        half_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd15)
                        begin
                            sio_stb <= 1'b1;  // Clock stays high
                            state   <= TM_DONE;
                        end
                        else
                        begin
                            sio_clk <= 1'b0;
                            state   <= TM_SHIFT_LOW;
                        end
                    end
                    else
                        half_cnt <= half_cnt + 1'b1;
                default:
                    if (!disp.ack)
                        disp.ack <= 1'b1;  // One cycle after stb rises
                    else if (!disp.req)
                    begin
                        disp.ack <= 1'b0;
                        state    <= TM_IDLE;
                    end
            endcase
        end
    end

    a_ack_after_stb: assert property (@(posedge clk) disable iff (rst)
        disp.ack |-> sio_stb);

    // Lab side addresses exactly one digit
    a_digit_onehot: assert property (@(posedge clk) disable iff (rst)
        disp.req |-> $onehot(disp.digit));

endmodule

`default_nettype wire

// ==== hw/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module board_top
#(
    parameter int screen_width  = 800,
    parameter int screen_height = 480,
    parameter int tick_div      = `TICK_DIV
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] key,
    input  logic [4:0] sw,
    output logic       lcd_de,
    output logic       lcd_hs,
    output logic       lcd_vs,
    output logic [4:0] lcd_r,
    output logic [5:0] lcd_g,
    output logic [4:0] lcd_b,
    output logic       sio_clk,
    output logic       sio_stb,
    output logic       sio_data
);

    localparam int w_x = $clog2(screen_width  + `LCD_H_BLANK);
    localparam int w_y = $clog2(screen_height + `LCD_V_BLANK);

    logic             tick;
    logic [w_x - 1:0] x;
    logic [w_y - 1:0] y;

    display_if disp ();

    // ----------------------------------------
    // Heartbeat and LCD timing

    tick_gen #(.tick_div(tick_div)) i_tick_gen
    (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    lcd_timing
    #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .w_x           (w_x),
        .w_y           (w_y)
    )
    i_lcd_timing
    (
        .clk (clk),
        .rst (rst),
        .de  (lcd_de),
        .hs  (lcd_hs),
        .vs  (lcd_vs),
        .x   (x),
        .y   (y)
    );

    // ----------------------------------------
    // Lab logic and TM1638 link

    lab_core
    #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .w_x           (w_x),
        .w_y           (w_y)
    )
    i_lab_core
    (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .key   (key),
        .sw    (sw),
        .de    (lcd_de),
        .x     (x),
        .y     (y),
        .red   (lcd_r),
        .green (lcd_g),
        .blue  (lcd_b),
        .disp  (disp.lab)
    );

    tm1638_ctrl i_tm1638
    (
        .clk      (clk),
        .rst      (rst),
        .disp     (disp.ctrl),
        .sio_clk  (sio_clk),
        .sio_stb  (sio_stb),
        .sio_data (sio_data)
    );

endmodule

`default_nettype wire

// ==== tests/tb_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module tb_board_top
    import board_pkg::*;
;

    localparam int screen_width    = 16;
    localparam int screen_height   = 8;
    localparam int tick_div        = `TICK_DIV;
    localparam int h_total         = screen_width + `LCD_H_BLANK;
    localparam int v_total         = screen_height + `LCD_V_BLANK;
    localparam int frame_cycles    = h_total * v_total;
    localparam int frames_per_mode = 2;
    localparam int mode_ticks      = (4 * frames_per_mode * frame_cycles) / tick_div + 1;
    localparam int count_ticks     = 6;
    localparam int clear_ticks     = 5;  // Settle, clear frame, three quiet periods
    localparam int total_ticks     = mode_ticks + count_ticks + clear_ticks;
    localparam int watchdog_ns     = total_ticks * tick_div * 10 * 2;
    localparam logic [31:0] lcg_seed = 32'd84846;

    // Segment masks, bit n set when the segment is lit for hex digit n
    localparam logic [15:0] seg_a = 16'hd7ed;
    localparam logic [15:0] seg_b = 16'h279f;
    localparam logic [15:0] seg_c = 16'h2ffb;
    localparam logic [15:0] seg_d = 16'h7b6d;
    localparam logic [15:0] seg_e = 16'hfd45;
    localparam logic [15:0] seg_f = 16'hdf71;
    localparam logic [15:0] seg_g = 16'hef7c;

    logic       clk = 1'b0;
    logic       rst;
    logic [2:0] key;
    logic [4:0] sw;
    logic       lcd_de;
    logic       lcd_hs;
    logic       lcd_vs;
    logic [4:0] lcd_r;
    logic [5:0] lcd_g;
    logic [4:0] lcd_b;
    logic       sio_clk;
    logic       sio_stb;
    logic       sio_data;

    logic [31:0] lcg_state;
    int          lcd_errs;
    int          serial_errs;
    int          main_errs;

    // Reference model state
    int         ref_cyc;
    logic [7:0] ref_count;
    disp_mode_t ref_mode;

    // LCD monitor state
    logic        prev_de;
    logic        prev_hs;
    logic        prev_vs;
    int          mon_x;
    int          mon_y;
    int          de_line;
    int          de_frame;
    int          hs_period;
    int          vs_period;
    int          hs_low;
    int          vs_low;
    int          since_de_fall;
    logic [15:0] exp_rgb;

    // Serial monitor state
    logic        prev_sclk;
    logic        prev_stb;
    logic        prev_sdata;
    int          nbits;
    logic [15:0] rx_word;
    logic [7:0]  rx_leds_q[$];
    logic [7:0]  rx_seg_q[$];

    board_top
    #(
        .screen_width  (screen_width),
        .screen_height (screen_height)
    )
    dut0
    (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .lcd_de   (lcd_de),
        .lcd_hs   (lcd_hs),
        .lcd_vs   (lcd_vs),
        .lcd_r    (lcd_r),
        .lcd_g    (lcd_g),
        .lcd_b    (lcd_b),
        .sio_clk  (sio_clk),
        .sio_stb  (sio_stb),
        .sio_data (sio_data)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Reference functions

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] seg_ref(input logic [3:0] d);
        return {1'b0, seg_g[d], seg_f[d], seg_e[d], seg_d[d], seg_c[d], seg_b[d], seg_a[d]};
    endfunction

    function automatic logic [15:0] color_ref(input disp_mode_t m, input int px, input int py,
                                              input logic [4:0] s, input logic [7:0] cnt);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = '0;
        g = '0;
        b = '0;
        case (m)
            MODE_PLAIN:
            begin
                r = s;
                g = {s, s[4]};
                b = s;
            end
            MODE_STRIPES: if (px[2]) r = 5'h1f;
            MODE_CHECKER:
                if (px[2] ^ py[2])
                begin
                    r = 5'h1f;
                    g = 6'h3f;
                    b = 5'h1f;
                end
            default: g = cnt[7:2];
        endcase
        return {r, g, b};
    endfunction

    function automatic logic tick_due(input int cyc);
        return (cyc > 0) && (cyc % tick_div == 0);  // First tick tick_div cycles after reset
    endfunction

    function automatic logic [7:0] next_count(input logic [7:0] cur, input logic t,
                                              input logic s0, input logic clr);
        if (clr)
            return 8'd0;
        if (t && s0)
            return cur + 8'd1;
        return cur;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    endtask

    task automatic show_problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Counter and mode as the board rules give them
    always @(posedge clk)
    begin
        if (rst)
        begin
            ref_cyc   <= 0;
            ref_count <= 8'd0;
            ref_mode  <= MODE_PLAIN;
        end
        else
        begin
            ref_cyc   <= ref_cyc + 1;
            ref_count <= next_count(ref_count, tick_due(ref_cyc), sw[0], key[0]);
            if (key[1] || key[2])
                ref_mode <= disp_mode_t'(key[2:1]);
        end
    end

    // ----------------------------------------
    // LCD monitor, own x and y from de edges

    always @(posedge clk)
    begin
        if (rst)
        begin
            prev_de       = 1'b0;
            prev_hs       = 1'b1;
            prev_vs       = 1'b1;
            mon_x         = 0;
            mon_y         = 0;
            de_line       = 0;
            de_frame      = 0;
            hs_period     = -1;  // No edge seen yet
            vs_period     = -1;
            hs_low        = 0;
            vs_low        = 0;
            since_de_fall = 0;
        end
        else
        begin
            if (prev_hs && !lcd_hs)
            begin
                if (hs_period >= 0 && hs_period != h_total)
                begin
                    show_mismatch("hs period", h_total, hs_period);
                    lcd_errs++;
                end
                hs_period = 0;
                hs_low    = 0;
            end
            if (!prev_hs && lcd_hs && hs_low != `LCD_HS_LEN)
            begin
                show_mismatch("hs low cycles", `LCD_HS_LEN, hs_low);
                lcd_errs++;
            end
            if (prev_vs && !lcd_vs)
            begin
                if (vs_period >= 0 && vs_period != frame_cycles)
                begin
                    show_mismatch("vs period", frame_cycles, vs_period);
                    lcd_errs++;
                end
                if (de_frame != screen_width * screen_height)
                begin
                    show_mismatch("de cycles per frame", screen_width * screen_height, de_frame);
                    lcd_errs++;
                end
                if (since_de_fall != `LCD_H_BLANK)
                begin
                    show_problem("vs did not fall at the start of the first blank line");
                    lcd_errs++;
                end
                vs_period = 0;
                vs_low    = 0;
                de_frame  = 0;
                mon_y     = 0;
            end
            if (!prev_vs && lcd_vs && vs_low != `LCD_VS_LEN * h_total)
            begin
                show_mismatch("vs low cycles", `LCD_VS_LEN * h_total, vs_low);
                lcd_errs++;
            end

            if (lcd_de)
            begin
                mon_x = prev_de ? mon_x + 1 : 0;
                de_line++;
                de_frame++;
                exp_rgb = color_ref(ref_mode, mon_x, mon_y, sw, ref_count);
                if ({lcd_r, lcd_g, lcd_b} != exp_rgb)
                begin
                    show_mismatch("lcd_rgb", 32'(exp_rgb), 32'({lcd_r, lcd_g, lcd_b}));
                    lcd_errs++;
                end
            end
            else
            begin
                if ({lcd_r, lcd_g, lcd_b} != 16'h0)
                begin
                    show_mismatch("lcd_rgb while blank", 0, 32'({lcd_r, lcd_g, lcd_b}));
                    lcd_errs++;
                end
                if (prev_de)
                begin
                    if (de_line != screen_width)
                    begin
                        show_mismatch("de cycles per line", screen_width, de_line);
                        lcd_errs++;
                    end
                    if (lcd_hs || !prev_hs)
                    begin
                        show_problem("hs did not fall at the first blank cycle");
                        lcd_errs++;
                    end
                    de_line       = 0;
                    mon_y         = mon_y + 1;
                    since_de_fall = 0;
                end
            end

            if (!lcd_hs)
                hs_low++;
            if (!lcd_vs)
                vs_low++;
            if (hs_period >= 0)
                hs_period++;
            if (vs_period >= 0)
                vs_period++;
            since_de_fall++;
            prev_de = lcd_de;
            prev_hs = lcd_hs;
            prev_vs = lcd_vs;
        end
    end

    // ----------------------------------------
    // Serial monitor, bits taken at sio_clk rise

    always @(posedge clk)
    begin
        if (rst)
        begin
            prev_sclk  = 1'b1;
            prev_stb   = 1'b1;
            prev_sdata = 1'b0;
            nbits      = 0;
            rx_word    = '0;
        end
        else
        begin
            if (prev_stb && !sio_stb)
            begin
                nbits   = 0;
                rx_word = '0;
            end
            if (!sio_stb && sio_clk && !prev_sclk)
            begin
                rx_word = {sio_data, rx_word[15:1]};  // LSB first
                nbits++;
            end
            if (sio_clk && prev_sclk && sio_data != prev_sdata)
            begin
                show_problem("sio_data changed while sio_clk was high");
                serial_errs++;
            end
            if (!prev_stb && sio_stb)
            begin
                if (nbits != 16)
                begin
                    show_mismatch("sio_clk edges per frame", 16, nbits);
                    serial_errs++;
                end
                if (rx_word[7:0] != seg_ref(rx_word[11:8]))
                begin
                    show_mismatch("segments", 32'(seg_ref(rx_word[11:8])), 32'(rx_word[7:0]));
                    serial_errs++;
                end
                if (rx_word[15:8] != ref_count)
                begin
                    show_mismatch("leds", 32'(ref_count), 32'(rx_word[15:8]));
                    serial_errs++;
                end
                rx_leds_q.push_back(rx_word[15:8]);
                rx_seg_q.push_back(rx_word[7:0]);
            end
            prev_sclk  = sio_clk;
            prev_stb   = sio_stb;
            prev_sdata = sio_data;
        end
    end

    // ----------------------------------------
    // Stimulus

    task automatic next_random_sw();
        lcg_state = lcg_next(lcg_state);
        sw        = lcg_state[20:16];
    endtask

    task automatic run_image(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (i % 37 == 0)
                next_random_sw();
        end
    endtask

    task automatic select_mode(input disp_mode_t m);
        @(negedge clk);
        key = {m, 1'b0};
        @(negedge clk);
        key = 3'b000;
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        key = 3'b001;
        @(negedge clk);
        key = 3'b000;
    endtask

    task automatic wait_frames(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (rx_leds_q.size() < target && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rx_leds_q.size() < target)
        begin
            show_problem("timed out waiting for a TM1638 frame");
            main_errs++;
        end
    endtask

    initial
    begin
        int         first;
        logic [7:0] exp_leds;
        rst         = 1'b1;
        key         = 3'b000;
        sw          = 5'b00000;
        lcg_state   = lcg_seed;
        lcd_errs    = 0;
        serial_errs = 0;
        main_errs   = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Every image mode with random switches
        run_image(frames_per_mode * frame_cycles);
        select_mode(MODE_STRIPES);
        run_image(frames_per_mode * frame_cycles);
        select_mode(MODE_CHECKER);
        run_image(frames_per_mode * frame_cycles);
        select_mode(MODE_COUNT);
        run_image(frames_per_mode * frame_cycles);

        // Counting frames
        @(negedge clk);
        sw[0] = 1'b1;
        first = rx_leds_q.size();
        wait_frames(first + 4, count_ticks * tick_div);
        for (int i = first + 1; i < rx_leds_q.size() && i < first + 4; i++)
        begin
            exp_leds = rx_leds_q[i - 1] + 8'd1;
            if (rx_leds_q[i] != exp_leds)
            begin
                show_mismatch("leds step", 32'(exp_leds), 32'(rx_leds_q[i]));
                main_errs++;
            end
        end

        // Clear, then hold with counting off
        @(negedge clk);
        sw[0] = 1'b0;
        repeat (tick_div) @(negedge clk);
        first = rx_leds_q.size();
        pulse_clear();
        wait_frames(first + 1, tick_div);
        if (rx_leds_q.size() > first)
        begin
            if (rx_leds_q[first] != 8'd0)
            begin
                show_mismatch("leds after clear", 0, 32'(rx_leds_q[first]));
                main_errs++;
            end
            if (rx_seg_q[first] != seg_ref(4'h0))
            begin
                show_mismatch("segments after clear", 32'(seg_ref(4'h0)), 32'(rx_seg_q[first]));
                main_errs++;
            end
        end
        first = rx_leds_q.size();
        repeat (3 * tick_div) @(negedge clk);
        if (rx_leds_q.size() != first)
        begin
            show_problem("a new frame appeared with sw[0] low");
            main_errs++;
        end

        $display("Error count: lcd %0d, serial %0d, sequence %0d",
                 lcd_errs, serial_errs, main_errs);
        if (lcd_errs + serial_errs + main_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(watchdog_ns);
        show_problem("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hw/board_pkg.sv
hw/display_if.sv
hw/tick_gen.sv
hw/lcd_timing.sv
hw/lab_core.sv
hw/tm1638_ctrl.sv
hw/board_top.sv
tests/tb_board_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the board testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_board_top \
    -f src.f \
    -o tb_board_top_sim

./obj_dir/tb_board_top_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
